// ==== verilog/mover_settings.svh ====
/*
 * Sizing constants for the stack-order data mover.
 * Include in any package or module that needs buffer or bus widths.
 */
`ifndef MOVER_SETTINGS_SVH
`define MOVER_SETTINGS_SVH

// buffer geometry, entries per stack
`define MOVER_DEPTH 16
`define MOVER_ADDR_W 4
// count reaches MOVER_DEPTH, so one bit wider than the address
`define MOVER_COUNT_W 5
`define MOVER_WORD_W 64

// register port
`define AXIL_DATA_W 32
`define AXIL_ADDR_W 8

// input stack read to output stack write, in cycles
`define MOVER_PIPE_DEPTH 3

`endif

// ==== verilog/mover_csr_pkg.sv ====
/*
 * Register-level types for the data mover: register map, CTRL bits,
 * AXI4-Lite request and response structs, and the command pulses.
 */
`include "mover_settings.svh"

package mover_csr_pkg;

    // word offsets, byte address is offset * 4
    typedef enum logic [`AXIL_ADDR_W-3:0] {
        CTRL    = 0,
        STATUS  = 1,
        PUSH_LO = 2,
        PUSH_HI = 3,
        OUT_LO  = 4,
        OUT_HI  = 5
    } csr_reg_e;

    // bit positions inside CTRL
    typedef enum logic [1:0] {
        CMD_PUSH  = 0,
        CMD_DRAIN = 1,
        CMD_POP   = 2,
        CMD_CLEAR = 3
    } ctrl_bit_e;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // everything the master drives
    typedef struct packed {
        logic [`AXIL_ADDR_W-1:0]     awaddr;
        logic                        awvalid;
        logic [`AXIL_DATA_W-1:0]     wdata;
        logic [`AXIL_DATA_W/8-1:0]   wstrb;
        logic                        wvalid;
        logic                        bready;
        logic [`AXIL_ADDR_W-1:0]     araddr;
        logic                        arvalid;
        logic                        rready;
    } axil_req_t;

    // everything the slave drives
    typedef struct packed {
        logic                        awready;
        logic                        wready;
        logic [1:0]                  bresp;
        logic                        bvalid;
        logic                        arready;
        logic [`AXIL_DATA_W-1:0]     rdata;
        logic [1:0]                  rresp;
        logic                        rvalid;
    } axil_rsp_t;

    // one-cycle pulses, push_word valid alongside push
    typedef struct packed {
        logic                        push;
        logic                        drain;
        logic                        pop;
        logic                        clear;
        logic [`MOVER_WORD_W-1:0]    push_word;
    } mover_cmd_t;

endpackage

// ==== verilog/mover_data_pkg.sv ====
/*
 * Data-level types shared by the two stacks and the register block:
 * the payload word, per-stack status, the transfer beat and the
 * drain sequencer states.
 */
`include "mover_settings.svh"

package mover_data_pkg;

    typedef logic [`MOVER_WORD_W-1:0] word_t;

    // count of stored words, sticky error and activity
    // err is overflow on the input side, underflow on the output side
    typedef struct packed {
        logic [`MOVER_COUNT_W-1:0] count;
        logic                      err;
        logic                      busy;
    } stack_status_t;

    // one word moving from input stack to output stack
    typedef struct packed {
        logic  valid;
        word_t word;
    } xfer_t;

    // drain sequencer of the input stack
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        DRAIN = 2'd1,
        FLUSH = 2'd2
    } drain_state_e;

endpackage

// ==== verilog/axil_csr_regs.sv ====
/*
 * AXI4-Lite register slave of the data mover. Holds the two push halves,
 * turns CTRL writes into one-cycle command pulses and serves STATUS and
 * the popped word. Single outstanding write and read.
 */
`timescale 1ns/1ps
`include "mover_settings.svh"

module axil_csr_regs
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  mover_csr_pkg::axil_req_t      axil_req,
    output mover_csr_pkg::axil_rsp_t      axil_rsp,
    output mover_csr_pkg::mover_cmd_t     cmd,
    input  mover_data_pkg::stack_status_t in_status,
    input  mover_data_pkg::stack_status_t out_status,
    input  mover_data_pkg::word_t         out_word
);

    logic                      aw_ready;
    logic                      ar_ready;
    logic                      b_valid;
    logic                      r_valid;
    logic                      aw_hs;
    logic                      ar_hs;
    logic [`AXIL_DATA_W-1:0]   r_data;
    logic [`AXIL_DATA_W-1:0]   rd_mux;
    logic [`AXIL_DATA_W-1:0]   push_lo;
    logic [`AXIL_DATA_W-1:0]   push_hi;
    // pulse bits indexed by ctrl_bit_e
    logic [3:0]                pulse;
    mover_csr_pkg::csr_reg_e   wr_reg;
    mover_csr_pkg::csr_reg_e   rd_reg;

    // word offset from byte address
    assign wr_reg = mover_csr_pkg::csr_reg_e'(axil_req.awaddr[`AXIL_ADDR_W-1:2]);
    assign rd_reg = mover_csr_pkg::csr_reg_e'(axil_req.araddr[`AXIL_ADDR_W-1:2]);

    assign aw_hs = aw_ready && axil_req.awvalid && axil_req.wvalid;
    assign ar_hs = ar_ready && axil_req.arvalid;

    // handshake and pulse state
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            aw_ready <= 1'b0;
            ar_ready <= 1'b0;
            b_valid  <= 1'b0;
            r_valid  <= 1'b0;
            pulse    <= '0;
        end
        else
        begin
            // address and data accepted together, one cycle wide
            aw_ready <= axil_req.awvalid && axil_req.wvalid && !b_valid && !aw_ready;
            ar_ready <= axil_req.arvalid && !r_valid && !ar_ready;
            pulse    <= '0;

            if (aw_hs)
            begin
                b_valid <= 1'b1;
                if (wr_reg == mover_csr_pkg::CTRL && axil_req.wstrb[0])
                begin
                    pulse[mover_csr_pkg::CMD_PUSH]  <= axil_req.wdata[mover_csr_pkg::CMD_PUSH];
                    pulse[mover_csr_pkg::CMD_DRAIN] <= axil_req.wdata[mover_csr_pkg::CMD_DRAIN];
                    pulse[mover_csr_pkg::CMD_POP]   <= axil_req.wdata[mover_csr_pkg::CMD_POP];
                    pulse[mover_csr_pkg::CMD_CLEAR] <= axil_req.wdata[mover_csr_pkg::CMD_CLEAR];
                end
            end
            else if (b_valid && axil_req.bready)
                b_valid <= 1'b0;

            // read response held until rready
            if (ar_hs)
                r_valid <= 1'b1;
            else if (r_valid && axil_req.rready)
                r_valid <= 1'b0;
        end
    end

    // push halves with byte strobes, read data capture
    always_ff @(posedge clk)
    begin
        if (aw_hs)
        begin
            for (int b = 0; b < `AXIL_DATA_W/8; b++)
            begin
                if (axil_req.wstrb[b] && wr_reg == mover_csr_pkg::PUSH_LO)
                    push_lo[b*8 +: 8] <= axil_req.wdata[b*8 +: 8];
                if (axil_req.wstrb[b] && wr_reg == mover_csr_pkg::PUSH_HI)
                    push_hi[b*8 +: 8] <= axil_req.wdata[b*8 +: 8];
            end
        end
        if (ar_hs)
            r_data <= rd_mux;
    end

    // read mux, CTRL and unmapped offsets give zero
    always_comb
    begin
        rd_mux = '0;
        case (rd_reg)
            mover_csr_pkg::STATUS:
            begin
                rd_mux[`MOVER_COUNT_W-1:0]    = in_status.count;
                rd_mux[8 +: `MOVER_COUNT_W]   = out_status.count;
                rd_mux[16]                    = in_status.busy || out_status.busy;
                rd_mux[17]                    = in_status.err;
                rd_mux[18]                    = out_status.err;
            end
            mover_csr_pkg::PUSH_LO: rd_mux = push_lo;
            mover_csr_pkg::PUSH_HI: rd_mux = push_hi;
            mover_csr_pkg::OUT_LO:  rd_mux = out_word[`AXIL_DATA_W-1:0];
            mover_csr_pkg::OUT_HI:  rd_mux = out_word[`MOVER_WORD_W-1:`AXIL_DATA_W];
            default:                rd_mux = '0;
        endcase
    end

    assign axil_rsp = '{awready: aw_ready,
                        wready:  aw_ready,
                        bresp:   mover_csr_pkg::RESP_OKAY,
                        bvalid:  b_valid,
                        arready: ar_ready,
                        rdata:   r_data,
                        rresp:   mover_csr_pkg::RESP_OKAY,
                        rvalid:  r_valid};

    // PUSH_HI is the upper half of the pushed word
    assign cmd = '{push:      pulse[mover_csr_pkg::CMD_PUSH],
                   drain:     pulse[mover_csr_pkg::CMD_DRAIN],
                   pop:       pulse[mover_csr_pkg::CMD_POP],
                   clear:     pulse[mover_csr_pkg::CMD_CLEAR],
                   push_word: {push_hi, push_lo}};

    // a stalled write response blocks the next write handshake
    a_bresp_held: assert property (@(posedge clk) disable iff (!reset_n)
        (b_valid && !axil_req.bready) |=> (b_valid && !aw_ready));

    // read data stays put while the master stalls
    a_rdata_held: assert property (@(posedge clk) disable iff (!reset_n)
        (r_valid && !axil_req.rready) |=> (r_valid && $stable(r_data)));

endmodule

// ==== verilog/input_stack.sv ====
/*
 * Input buffer of the data mover. Pushes land on top of the stack; a drain
 * command pops every word, newest first, through the memory read and two
 * alignment stages onto the xfer beat, paced by out_space.
 */
`timescale 1ns/1ps
`include "mover_settings.svh"

module input_stack
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  mover_csr_pkg::mover_cmd_t     cmd,
    input  logic                          out_space,
    output mover_data_pkg::xfer_t         xfer,
    output mover_data_pkg::stack_status_t status
);

    mover_data_pkg::word_t        mem [`MOVER_DEPTH];
    // top of stack, equals the word count
    logic [`MOVER_COUNT_W-1:0]    ptr;
    logic [`MOVER_COUNT_W-1:0]    ptr_dec;
    logic                         wr_en;
    mover_data_pkg::word_t        wr_word;
    logic                         overflow;
    logic                         full;
    logic                         push_ok;
    logic                         rd_issue;
    mover_data_pkg::drain_state_e state;
    // stage 0 is the memory read, the rest align
    logic [`MOVER_PIPE_DEPTH-1:0] pipe_valid;
    mover_data_pkg::word_t        pipe_word [`MOVER_PIPE_DEPTH];

    assign ptr_dec = ptr - 1'b1;

    // a write still pending counts as taken
    assign full = (ptr == `MOVER_COUNT_W'(`MOVER_DEPTH))
               || (wr_en && ptr == `MOVER_COUNT_W'(`MOVER_DEPTH - 1));

    // pushes only while idle, drain owns the pointer otherwise
    assign push_ok = cmd.push && !full && state == mover_data_pkg::IDLE;

    // one read per cycle while the output side has room
    assign rd_issue = state == mover_data_pkg::DRAIN && out_space
                   && ptr != '0 && !wr_en;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state      <= mover_data_pkg::IDLE;
            ptr        <= '0;
            wr_en      <= 1'b0;
            overflow   <= 1'b0;
            pipe_valid <= '0;
        end
        else
        begin
            // write lands one cycle after the pulse
            wr_en <= push_ok;

            // rejected push, full or mid-drain, is sticky
            if (cmd.clear)
                overflow <= 1'b0;
            else if (cmd.push && !push_ok)
                overflow <= 1'b1;

            // increment on write, decrement on read
            if (wr_en)
                ptr <= ptr + 1'b1;
            else if (rd_issue)
                ptr <= ptr_dec;

            pipe_valid <= {pipe_valid[`MOVER_PIPE_DEPTH-2:0], rd_issue};

            case (state)
                mover_data_pkg::IDLE:
                    // empty stack, drain is a no-op
                    if (cmd.drain && (ptr != '0 || wr_en))
                        state <= mover_data_pkg::DRAIN;
                mover_data_pkg::DRAIN:
                    if (ptr == '0 && !wr_en)
                        state <= mover_data_pkg::FLUSH;
                mover_data_pkg::FLUSH:
                    // last words still travelling
                    if (!(|pipe_valid))
                        state <= mover_data_pkg::IDLE;
                default:
                    state <= mover_data_pkg::IDLE;
            endcase
        end
    end

    // memory and payload path
    always_ff @(posedge clk)
    begin
        if (push_ok)
            wr_word <= cmd.push_word;
        if (wr_en)
            mem[ptr[`MOVER_ADDR_W-1:0]] <= wr_word;
        pipe_word[0] <= mem[ptr_dec[`MOVER_ADDR_W-1:0]];
        for (int i = 1; i < `MOVER_PIPE_DEPTH; i++)
            pipe_word[i] <= pipe_word[i-1];
    end

    assign xfer = '{valid: pipe_valid[`MOVER_PIPE_DEPTH-1],
                    word:  pipe_word[`MOVER_PIPE_DEPTH-1]};

    assign status = '{count: ptr,
                      err:   overflow,
                      busy:  state != mover_data_pkg::IDLE};

    // pointer never wraps below zero
    a_no_wrap: assert property (@(posedge clk) disable iff (!reset_n)
        (ptr == '0) |=> (ptr <= `MOVER_COUNT_W'(1)));

endmodule

// ==== verilog/output_stack.sv ====
/*
 * Output buffer of the data mover. Takes xfer beats on top of the stack,
 * grants out_space as a credit to the drain, and serves pop commands
 * into the read-out word, newest first.
 */
`timescale 1ns/1ps
`include "mover_settings.svh"

module output_stack
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  mover_data_pkg::xfer_t         xfer,
    input  logic                          pop,
    input  logic                          clear,
    output logic                          out_space,
    output mover_data_pkg::word_t         out_word,
    output mover_data_pkg::stack_status_t status
);

    mover_data_pkg::word_t        mem [`MOVER_DEPTH];
    logic [`MOVER_COUNT_W-1:0]    ptr;
    logic [`MOVER_COUNT_W-1:0]    free;
    logic [`MOVER_COUNT_W-1:0]    inflight;
    // out_space over the last pipe-depth cycles
    logic [`MOVER_PIPE_DEPTH-1:0] grant_hist;
    logic                         pop_ok;
    logic                         pop_q;
    logic                         underflow;

    assign free = `MOVER_COUNT_W'(`MOVER_DEPTH) - ptr;

    // each granted cycle may have started one read upstream
    // so recent grants bound the words still in the pipe
    assign inflight = `MOVER_COUNT_W'($countones(grant_hist));

    // keeps a full pipe of margin, top entries stay unused
    assign out_space = free >= (`MOVER_COUNT_W'(`MOVER_PIPE_DEPTH) + inflight);

    // a pop colliding with intake is refused like an empty pop
    assign pop_ok = pop && ptr != '0 && !xfer.valid;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            ptr        <= '0;
            pop_q      <= 1'b0;
            underflow  <= 1'b0;
            grant_hist <= '0;
        end
        else
        begin
            pop_q      <= pop_ok;
            grant_hist <= {grant_hist[`MOVER_PIPE_DEPTH-2:0], out_space};

            if (clear)
                underflow <= 1'b0;
            else if (pop && !pop_ok)
                underflow <= 1'b1;

            // increment on write, decrement on pop
            if (xfer.valid)
                ptr <= ptr + 1'b1;
            else if (pop_ok)
                ptr <= ptr - 1'b1;
        end
    end

    // memory write and read-out word
    always_ff @(posedge clk)
    begin
        if (xfer.valid)
            mem[ptr[`MOVER_ADDR_W-1:0]] <= xfer.word;
        // ptr already points at the popped entry
        if (pop_q)
            out_word <= mem[ptr[`MOVER_ADDR_W-1:0]];
    end

    // busy while a beat is being taken in
    assign status = '{count: ptr,
                      err:   underflow,
                      busy:  xfer.valid};

    // credit keeps the drain from writing past the top
    a_no_overrun: assert property (@(posedge clk) disable iff (!reset_n)
        xfer.valid |-> (ptr < `MOVER_COUNT_W'(`MOVER_DEPTH)));

endmodule

// ==== verilog/data_mover_top.sv ====
/*
 * Top level of the stack-order data mover. AXI4-Lite is the only port;
 * the register block drives both stacks and collects their status.
 */
`timescale 1ns/1ps

module data_mover_top
(
    input  logic                     clk,
    input  logic                     reset_n,
    input  mover_csr_pkg::axil_req_t axil_req,
    output mover_csr_pkg::axil_rsp_t axil_rsp
);

    mover_csr_pkg::mover_cmd_t     cmd;
    mover_data_pkg::stack_status_t in_status;
    mover_data_pkg::stack_status_t out_status;
    mover_data_pkg::word_t         out_word;
    mover_data_pkg::xfer_t         xfer;
    logic                          out_space;

    // register port and command decode
    axil_csr_regs u_csr (
        .clk        (clk),
        .reset_n    (reset_n),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .cmd        (cmd),
        .in_status  (in_status),
        .out_status (out_status),
        .out_word   (out_word)
    );

    // push side, drains into the output stack
    input_stack u_in (
        .clk        (clk),
        .reset_n    (reset_n),
        .cmd        (cmd),
        .out_space  (out_space),
        .xfer       (xfer),
        .status     (in_status)
    );

    // pop side
    output_stack u_out (
        .clk        (clk),
        .reset_n    (reset_n),
        .xfer       (xfer),
        .pop        (cmd.pop),
        .clear      (cmd.clear),
        .out_space  (out_space),
        .out_word   (out_word),
        .status     (out_status)
    );

endmodule

// ==== testbench/tb_axil_tasks.svh ====
/*
 * AXI4-Lite master tasks for the data mover testbench: single write,
 * single read and a read that repeats until a field matches.
 * Included inside the testbench module, uses its clk, bus structs and value check.
 */
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// one write with address and data offered together
task automatic write_reg(input logic [`AXIL_ADDR_W-1:0] addr,
                         input logic [`AXIL_DATA_W-1:0] data);
    begin
        @(negedge clk);
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.wstrb   = '1;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        axil_req.bready  = 1'b1;
        // registered ready shows up after the next edge
        @(negedge clk);
        while (!axil_rsp.awready)
            @(negedge clk);
        // wready rises together with awready
        check_value("write ready", 64'(1), 64'(axil_rsp.wready));
        @(negedge clk);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        // response retires on the next edge since bready is high
        while (!axil_rsp.bvalid)
            @(negedge clk);
        check_value("write response", 64'(RESP_OKAY), 64'(axil_rsp.bresp));
    end
endtask

// one read with data taken while rvalid is stable
task automatic read_reg(input  logic [`AXIL_ADDR_W-1:0] addr,
                        output logic [`AXIL_DATA_W-1:0] data);
    begin
        @(negedge clk);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        axil_req.rready  = 1'b1;
        @(negedge clk);
        while (!axil_rsp.arready)
            @(negedge clk);
        @(negedge clk);
        axil_req.arvalid = 1'b0;
        while (!axil_rsp.rvalid)
            @(negedge clk);
        check_value("read response", 64'(RESP_OKAY), 64'(axil_rsp.rresp));
        data = axil_rsp.rdata;
    end
endtask

// reread until the masked bits match
task automatic poll_reg(input  logic [`AXIL_ADDR_W-1:0] addr,
                        input  logic [`AXIL_DATA_W-1:0] mask,
                        input  logic [`AXIL_DATA_W-1:0] value,
                        output logic [`AXIL_DATA_W-1:0] data);
    begin
        read_reg(addr, data);
        while ((data & mask) != value)
            read_reg(addr, data);
    end
endtask

`endif

// ==== testbench/tb_data_mover.sv ====
/*
 * Testbench for the stack-order data mover. Pushes a random word table,
 * drains and pops it back over AXI4-Lite, then runs overflow with
 * back-pressure, underflow and clear, against a queue model of both stacks.
 */
`timescale 1ns/1ps
`include "mover_settings.svh"

module tb_data_mover;

    localparam int CLK_PERIOD = 100;
    localparam int TABLE_SIZE = 8;

    // byte addresses and CTRL bits of the register map
    localparam logic [`AXIL_ADDR_W-1:0] ADDR_CTRL     = 8'h00;
    localparam logic [`AXIL_ADDR_W-1:0] ADDR_STATUS   = 8'h04;
    localparam logic [`AXIL_ADDR_W-1:0] ADDR_PUSH_LO  = 8'h08;
    localparam logic [`AXIL_ADDR_W-1:0] ADDR_PUSH_HI  = 8'h0c;
    localparam logic [`AXIL_ADDR_W-1:0] ADDR_OUT_LO   = 8'h10;
    localparam logic [`AXIL_ADDR_W-1:0] ADDR_OUT_HI   = 8'h14;
    localparam logic [`AXIL_ADDR_W-1:0] ADDR_UNMAPPED = 8'h3c;
    localparam logic [31:0] CMD_PUSH  = 32'h1;
    localparam logic [31:0] CMD_DRAIN = 32'h2;
    localparam logic [31:0] CMD_POP   = 32'h4;
    localparam logic [31:0] CMD_CLEAR = 32'h8;
    localparam logic [31:0] BUSY_MASK      = 32'h0001_0000;
    localparam logic [31:0] OUT_COUNT_MASK = 32'h0000_1f00;
    // AXI response code for a good write or read
    localparam logic [1:0]  RESP_OKAY = 2'b00;

    // transactions per test with polls rounded up
    localparam int XACTS = 5 + 25 + 8 + 41 + 115 + 7;
    // a write or read spans about three cycles
    localparam int EXPECTED_CYCLES = 3 * XACTS + 3;
    localparam int TIMEOUT_CYCLES  = 20 * EXPECTED_CYCLES;

    logic                     clk;
    logic                     reset_n;
    mover_csr_pkg::axil_req_t axil_req;
    mover_csr_pkg::axil_rsp_t axil_rsp;

    // stimulus table
    string                 tbl_name   [TABLE_SIZE];
    mover_data_pkg::word_t tbl_word   [TABLE_SIZE];
    bit                    tbl_reread [TABLE_SIZE];

    integer seed;
    int     err_count   = 0;
    int     check_count = 0;
    int     cycle_count = 0;

    // stack model with the back of each queue as the top
    mover_data_pkg::word_t in_model  [$];
    mover_data_pkg::word_t out_model [$];
    mover_data_pkg::word_t last_out  = '0;
    bit                    drain_active = 1'b0;
    bit                    ovf_model    = 1'b0;
    bit                    unf_model    = 1'b0;

    data_mover_top u_dut (
        .clk      (clk),
        .reset_n  (reset_n),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    `include "tb_axil_tasks.svh"

    initial
    begin
        clk = 1'b0;
        forever
            #(CLK_PERIOD / 2) clk = ~clk;
    end

    // watchdog
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("checks: %0d, errors: %0d", check_count, err_count);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        begin
            check_count++;
            assert (actual === expected)
            else
            begin
                $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
                err_count++;
            end
        end
    endtask

    // STATUS layout of both counts, busy and the two sticky flags
    function automatic logic [31:0] status_word(input int in_cnt, input int out_cnt,
                                                input bit busy, input bit ovf,
                                                input bit unf);
        logic [31:0] w;
        w        = '0;
        w[4:0]   = in_cnt[4:0];
        w[12:8]  = out_cnt[4:0];
        w[16]    = busy;
        w[17]    = ovf;
        w[18]    = unf;
        return w;
    endfunction

    function automatic logic [31:0] expected_status();
        return status_word(in_model.size(), out_model.size(), drain_active,
                           ovf_model, unf_model);
    endfunction

    task automatic expect_status(input string name);
        logic [31:0] data;
        begin
            read_reg(ADDR_STATUS, data);
            check_value(name, 64'(expected_status()), 64'(data));
        end
    endtask

    // drain moves a word only while stored plus in-flight words
    // stay within depth minus pipe depth
    task automatic settle_model();
        begin
            while (drain_active && in_model.size() != 0
                   && out_model.size() <= `MOVER_DEPTH - `MOVER_PIPE_DEPTH)
                out_model.push_back(in_model.pop_back());
            if (in_model.size() == 0)
                drain_active = 1'b0;
        end
    endtask

    task automatic push_entry(input mover_data_pkg::word_t word);
        begin
            write_reg(ADDR_PUSH_LO, word[31:0]);
            write_reg(ADDR_PUSH_HI, word[63:32]);
            write_reg(ADDR_CTRL, CMD_PUSH);
            // full or busy stack drops the word
            if (drain_active || in_model.size() == `MOVER_DEPTH)
                ovf_model = 1'b1;
            else
                in_model.push_back(word);
        end
    endtask

    task automatic start_drain();
        begin
            write_reg(ADDR_CTRL, CMD_DRAIN);
            if (!drain_active && in_model.size() != 0)
                drain_active = 1'b1;
            settle_model();
        end
    endtask

    // pop and read OUT back once or twice
    task automatic pop_entry(input string name, input bit reread);
        mover_data_pkg::word_t expected;
        logic [31:0]           hi;
        logic [31:0]           lo;
        begin
            if (out_model.size() == 0)
            begin
                // empty pop leaves OUT alone
                unf_model = 1'b1;
                expected  = last_out;
            end
            else
            begin
                expected = out_model.pop_back();
                last_out = expected;
            end
            write_reg(ADDR_CTRL, CMD_POP);
            read_reg(ADDR_OUT_HI, hi);
            read_reg(ADDR_OUT_LO, lo);
            check_value(name, expected, {hi, lo});
            if (reread)
            begin
                read_reg(ADDR_OUT_HI, hi);
                read_reg(ADDR_OUT_LO, lo);
                check_value({name, " reread"}, expected, {hi, lo});
            end
            settle_model();
        end
    endtask

    initial
    begin
        int                    r;
        int                    n;
        logic [31:0]           data;
        mover_data_pkg::word_t w;

        axil_req = '0;
        reset_n  = 1'b0;
        seed     = 32'hc27b;
        for (int i = 0; i < TABLE_SIZE; i++)
        begin
            tbl_name[i]   = $sformatf("table_word_%0d", i);
            tbl_word[i]   = {$random(seed), $random(seed)};
            r             = $random(seed);
            tbl_reread[i] = r[0];
        end
        repeat (3) @(negedge clk);
        reset_n = 1'b1;

        // all handshake outputs idle out of reset
        check_value("handshake after reset", 64'(0),
                    64'({axil_rsp.awready, axil_rsp.wready, axil_rsp.bvalid,
                         axil_rsp.arready, axil_rsp.rvalid}));

        // reset state, unmapped space and CTRL read zero
        expect_status("status after reset");
        read_reg(ADDR_UNMAPPED, data);
        check_value("unmapped read", 64'(0), 64'(data));
        read_reg(ADDR_CTRL, data);
        check_value("ctrl read", 64'(0), 64'(data));
        write_reg(ADDR_UNMAPPED, 32'hffff_ffff);
        expect_status("status after unmapped write");

        for (int i = 0; i < TABLE_SIZE; i++)
            push_entry(tbl_word[i]);
        expect_status("status after table push");

        start_drain();
        poll_reg(ADDR_STATUS, BUSY_MASK, 32'h0, data);
        check_value("status after drain", 64'(expected_status()), 64'(data));

        // double reversal gives table order
        for (int i = 0; i < TABLE_SIZE; i++)
            pop_entry(tbl_name[i], tbl_reread[i]);
        expect_status("status after table pops");

        // one word more than the input stack holds
        for (int i = 0; i <= `MOVER_DEPTH; i++)
        begin
            w = {$random(seed), $random(seed)};
            push_entry(w);
        end
        expect_status("status after overflow push");

        // drain stalls on the space credit with words left behind
        start_drain();
        poll_reg(ADDR_STATUS, OUT_COUNT_MASK, 32'(out_model.size() << 8), data);
        check_value("status under back-pressure", 64'(expected_status()), 64'(data));

        // each pop frees room for one more word
        pop_entry("refill_pop_0", 1'b0);
        pop_entry("refill_pop_1", 1'b0);
        start_drain();
        poll_reg(ADDR_STATUS, BUSY_MASK, 32'h0, data);
        check_value("status after second drain", 64'(expected_status()), 64'(data));
        n = out_model.size();
        for (int i = 0; i < n; i++)
            pop_entry($sformatf("overflow_pop_%0d", i), 1'b0);
        expect_status("status after overflow pops");

        pop_entry("pop on empty", 1'b0);
        expect_status("status after empty pop");
        write_reg(ADDR_CTRL, CMD_CLEAR);
        ovf_model = 1'b0;
        unf_model = 1'b0;
        expect_status("status after clear");

        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== data_mover.f ====
+incdir+verilog
+incdir+testbench
verilog/mover_csr_pkg.sv
verilog/mover_data_pkg.sv
verilog/axil_csr_regs.sv
verilog/input_stack.sv
verilog/output_stack.sv
verilog/data_mover_top.sv
testbench/tb_data_mover.sv

// ==== Makefile ====
# Verilator build and run of the data mover testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_data_mover
FILELIST  := data_mover.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS   := $(wildcard verilog/*.svh testbench/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
